// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_backend
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed
PASS_MSG  = test passed

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: backend.sv
`timescale 1ns/1ps
`default_nettype none

module backend
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,

    input  logic                  inst_valid_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic [XLEN-1:0]       pc_i,

    output logic [XLEN-1:0]       debug_wb_pc_o,
    output logic [XLEN-1:0]       debug_wb_inst_o,
    output logic [3:0]            debug_wb_rf_wen_o,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]       debug_wb_rf_wdata_o,
    output logic                  debug_wb_ine_o
);

    // id
    logic                  id_valid;
    logic [XLEN-1:0]       id_pc;
    logic [XLEN-1:0]       id_inst;
    alu_op_t               id_alu_op;
    logic [REG_ADDR_W-1:0] id_rj;
    logic [REG_ADDR_W-1:0] id_rk;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [XLEN-1:0]       id_imm;
    logic                  id_use_imm;
    logic                  id_reg_write;
    logic                  id_ine;

    // regfile
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;

    // dispatch to ex
    logic                  ex_valid;
    logic [XLEN-1:0]       ex_pc;
    logic [XLEN-1:0]       ex_inst;
    alu_op_t               ex_alu_op;
    logic [XLEN-1:0]       ex_src1;
    logic [XLEN-1:0]       ex_src2;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_reg_write;
    logic                  ex_ine;

    // forwarding and wb
    logic                  ex_fwd_we;
    logic [REG_ADDR_W-1:0] ex_fwd_waddr;
    logic [XLEN-1:0]       ex_fwd_wdata;
    logic                  wb_valid;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_waddr;
    logic [XLEN-1:0]       wb_wdata;

    id u_id (
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .valid_o     (id_valid),
        .pc_o        (id_pc),
        .inst_o      (id_inst),
        .alu_op_o    (id_alu_op),
        .rj_o        (id_rj),
        .rk_o        (id_rk),
        .rd_o        (id_rd),
        .imm_o       (id_imm),
        .use_imm_o   (id_use_imm),
        .reg_write_o (id_reg_write),
        .ine_o       (id_ine)
    );

    dispatch u_dispatch (
        .clk,
        .rst_i,
        .valid_i       (id_valid),
        .pc_i          (id_pc),
        .inst_i        (id_inst),
        .alu_op_i      (id_alu_op),
        .rj_i          (id_rj),
        .rk_i          (id_rk),
        .rd_i          (id_rd),
        .imm_i         (id_imm),
        .use_imm_i     (id_use_imm),
        .reg_write_i   (id_reg_write),
        .ine_i         (id_ine),
        .rf_raddr1_o   (rf_raddr1),
        .rf_raddr2_o   (rf_raddr2),
        .rf_rdata1_i   (rf_rdata1),
        .rf_rdata2_i   (rf_rdata2),
        .ex_fwd_we_i   (ex_fwd_we),
        .ex_fwd_waddr_i(ex_fwd_waddr),
        .ex_fwd_wdata_i(ex_fwd_wdata),
        .wb_fwd_we_i   (wb_we),
        .wb_fwd_waddr_i(wb_waddr),
        .wb_fwd_wdata_i(wb_wdata),
        .ex_valid_o    (ex_valid),
        .ex_pc_o       (ex_pc),
        .ex_inst_o     (ex_inst),
        .ex_alu_op_o   (ex_alu_op),
        .ex_src1_o     (ex_src1),
        .ex_src2_o     (ex_src2),
        .ex_rd_o       (ex_rd),
        .ex_reg_write_o(ex_reg_write),
        .ex_ine_o      (ex_ine)
    );

    regfile u_regfile (
        .clk,
        .rst_i,
        .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2),
        .we_i    (wb_we),
        .waddr_i (wb_waddr),
        .wdata_i (wb_wdata)
    );

    ex u_ex (
        .clk,
        .rst_i,
        .ex_valid_i    (ex_valid),
        .ex_pc_i       (ex_pc),
        .ex_inst_i     (ex_inst),
        .ex_alu_op_i   (ex_alu_op),
        .ex_src1_i     (ex_src1),
        .ex_src2_i     (ex_src2),
        .ex_rd_i       (ex_rd),
        .ex_reg_write_i(ex_reg_write),
        .ex_ine_i      (ex_ine),
        .fwd_we_o      (ex_fwd_we),
        .fwd_waddr_o   (ex_fwd_waddr),
        .fwd_wdata_o   (ex_fwd_wdata),
        .wb_valid_o    (wb_valid),
        .wb_pc_o       (debug_wb_pc_o),
        .wb_inst_o     (debug_wb_inst_o),
        .wb_we_o       (wb_we),
        .wb_waddr_o    (wb_waddr),
        .wb_wdata_o    (wb_wdata),
        .wb_ine_o      (debug_wb_ine_o)
    );

    // writes to r0 are not reported
    assign debug_wb_rf_wen_o   = {4{wb_valid & wb_we & (wb_waddr != '0)}};
    assign debug_wb_rf_wnum_o  = wb_waddr;
    assign debug_wb_rf_wdata_o = wb_wdata;

endmodule

`default_nettype wire

// File: backend_golden.txt
# valid pc inst wen wnum wdata ine, all hex, one instruction slot per line
# wnum and wdata are compared only where wen is nonzero
1 1c000000 142468a1 f 01 12345000 0
1 1c000004 02bffc02 f 02 ffffffff 0
1 1c000008 02848c03 f 03 00000123 0
1 1c00000c 00100c24 f 04 12345123 0
1 1c000010 00110885 f 05 12345124 0
1 1c000014 00120c46 f 06 00000001 0
1 1c000018 00120867 f 07 00000000 0
1 1c00001c 00149488 f 08 12345120 0
1 1c000020 00151489 f 09 12345127 0
1 1c000024 0015948a f 0a 00000007 0
1 1c000028 0010254b f 0b 1234512e 0
1 1c00002c 02801420 0 00 12345005 0
1 1c000030 0010040c f 0c 12345000 0
0 1c000034 00000000 0 00 00000000 0
1 1c000038 ffffffff 0 00 00000000 1
1 1c00003c 02bfc18d f 0d 12344ff0 0
1 1c000040 001105ae f 0e fffffff0 0
1 1c000044 001201cf f 0f 00000001 0
1 1c000048 15ffffe1 f 01 fffff000 0
1 1c00004c 00153c30 f 10 fffff001 0

// File: backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // 17-bit major opcodes, inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2ri12 form, inst[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;

    // 1ri20 form, inst[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // field positions
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;
    localparam int SI12_LSB = 10;
    localparam int SI20_LSB = 5;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_NOP
    } alu_op_t;

endpackage

`default_nettype wire

// File: dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,

    input  logic                  valid_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       inst_i,
    input  alu_op_t               alu_op_i,
    input  logic [REG_ADDR_W-1:0] rj_i,
    input  logic [REG_ADDR_W-1:0] rk_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  use_imm_i,
    input  logic                  reg_write_i,
    input  logic                  ine_i,

    output logic [REG_ADDR_W-1:0] rf_raddr1_o,
    output logic [REG_ADDR_W-1:0] rf_raddr2_o,
    input  logic [XLEN-1:0]       rf_rdata1_i,
    input  logic [XLEN-1:0]       rf_rdata2_i,

    input  logic                  ex_fwd_we_i,
    input  logic [REG_ADDR_W-1:0] ex_fwd_waddr_i,
    input  logic [XLEN-1:0]       ex_fwd_wdata_i,
    input  logic                  wb_fwd_we_i,
    input  logic [REG_ADDR_W-1:0] wb_fwd_waddr_i,
    input  logic [XLEN-1:0]       wb_fwd_wdata_i,

    output logic                  ex_valid_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [XLEN-1:0]       ex_inst_o,
    output alu_op_t               ex_alu_op_o,
    output logic [XLEN-1:0]       ex_src1_o,
    output logic [XLEN-1:0]       ex_src2_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic                  ex_reg_write_o,
    output logic                  ex_ine_o
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] rk_val;
    logic [XLEN-1:0] src2;

    // newest value wins: ex, then wb, then regfile
    function automatic logic [XLEN-1:0] fwd_pick(input logic [REG_ADDR_W-1:0] addr,
                                                 input logic [XLEN-1:0]       rf_data);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_fwd_we_i && ex_fwd_waddr_i == addr) begin
            value = ex_fwd_wdata_i;
        end else if (wb_fwd_we_i && wb_fwd_waddr_i == addr) begin
            value = wb_fwd_wdata_i;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rf_raddr1_o = rj_i;
    assign rf_raddr2_o = rk_i;

    assign src1   = fwd_pick(rj_i, rf_rdata1_i);
    assign rk_val = fwd_pick(rk_i, rf_rdata2_i);
    assign src2   = use_imm_i ? imm_i : rk_val;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o     <= 1'b0;
            ex_reg_write_o <= 1'b0;
            ex_ine_o       <= 1'b0;
        end else begin
            ex_valid_o     <= valid_i;
            ex_reg_write_o <= valid_i & reg_write_i;
            ex_ine_o       <= valid_i & ine_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o     <= pc_i;
        ex_inst_o   <= inst_i;
        ex_alu_op_o <= alu_op_i;
        ex_src1_o   <= src1;
        ex_src2_o   <= src2;
        ex_rd_o     <= rd_i;
    end

endmodule

`default_nettype wire

// File: ex.sv
`timescale 1ns/1ps
`default_nettype none

module ex
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,

    input  logic                  ex_valid_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  logic [XLEN-1:0]       ex_inst_i,
    input  alu_op_t               ex_alu_op_i,
    input  logic [XLEN-1:0]       ex_src1_i,
    input  logic [XLEN-1:0]       ex_src2_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic                  ex_reg_write_i,
    input  logic                  ex_ine_i,

    output logic                  fwd_we_o,
    output logic [REG_ADDR_W-1:0] fwd_waddr_o,
    output logic [XLEN-1:0]       fwd_wdata_o,

    output logic                  wb_valid_o,
    output logic [XLEN-1:0]       wb_pc_o,
    output logic [XLEN-1:0]       wb_inst_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_waddr_o,
    output logic [XLEN-1:0]       wb_wdata_o,
    output logic                  wb_ine_o
);

    logic [XLEN-1:0] result;
    logic            less;

    assign less = $signed(ex_src1_i) < $signed(ex_src2_i);

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD: result = ex_src1_i + ex_src2_i;
            ALU_SUB: result = ex_src1_i - ex_src2_i;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, less};
            ALU_AND: result = ex_src1_i & ex_src2_i;
            ALU_OR:  result = ex_src1_i | ex_src2_i;
            ALU_XOR: result = ex_src1_i ^ ex_src2_i;
            // immediate already shifted by the decoder
            ALU_LUI: result = ex_src2_i;
            default: result = '0;
        endcase
    end

    assign fwd_we_o    = ex_valid_i & ex_reg_write_i;
    assign fwd_waddr_o = ex_rd_i;
    assign fwd_wdata_o = result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_ine_o   <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i;
            wb_we_o    <= ex_valid_i & ex_reg_write_i;
            wb_ine_o   <= ex_valid_i & ex_ine_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o    <= ex_pc_i;
        wb_inst_o  <= ex_inst_i;
        wb_waddr_o <= ex_rd_i;
        wb_wdata_o <= result;
    end

endmodule

`default_nettype wire

// File: id.sv
`timescale 1ns/1ps
`default_nettype none

module id
    import backend_pkg::*;
(
    input  logic                  inst_valid_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic [XLEN-1:0]       pc_i,

    output logic                  valid_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       inst_o,
    output alu_op_t               alu_op_o,
    output logic [REG_ADDR_W-1:0] rj_o,
    output logic [REG_ADDR_W-1:0] rk_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  use_imm_o,
    output logic                  reg_write_o,
    output logic                  ine_o
);

    logic            legal;
    logic [XLEN-1:0] imm_si12;
    logic [XLEN-1:0] imm_ui20;

    assign valid_o = inst_valid_i;
    assign pc_o    = pc_i;
    assign inst_o  = inst_i;

    assign rd_o = inst_i[RD_LSB +: REG_ADDR_W];
    assign rj_o = inst_i[RJ_LSB +: REG_ADDR_W];
    assign rk_o = inst_i[RK_LSB +: REG_ADDR_W];

    assign imm_si12 = {{(XLEN-12){inst_i[SI12_LSB+11]}}, inst_i[SI12_LSB +: 12]};
    // lu12i.w value lands in the upper 20 bits
    assign imm_ui20 = {inst_i[SI20_LSB +: 20], 12'b0};

    always_comb begin
        alu_op_o  = ALU_NOP;
        use_imm_o = 1'b0;
        imm_o     = imm_si12;
        legal     = 1'b1;
        if (inst_i[31:15] == OP_ADD_W) begin
            alu_op_o = ALU_ADD;
        end else if (inst_i[31:15] == OP_SUB_W) begin
            alu_op_o = ALU_SUB;
        end else if (inst_i[31:15] == OP_SLT) begin
            alu_op_o = ALU_SLT;
        end else if (inst_i[31:15] == OP_AND) begin
            alu_op_o = ALU_AND;
        end else if (inst_i[31:15] == OP_OR) begin
            alu_op_o = ALU_OR;
        end else if (inst_i[31:15] == OP_XOR) begin
            alu_op_o = ALU_XOR;
        end else if (inst_i[31:22] == OP_ADDI_W) begin
            alu_op_o  = ALU_ADD;
            use_imm_o = 1'b1;
        end else if (inst_i[31:25] == OP_LU12I_W) begin
            alu_op_o  = ALU_LUI;
            use_imm_o = 1'b1;
            imm_o     = imm_ui20;
        end else begin
            legal = 1'b0;
        end
    end

    assign reg_write_o = legal;
    // only a real instruction can be illegal
    assign ine_o = inst_valid_i & ~legal;

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,

    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,

    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend
    import backend_pkg::*;
();

    localparam int CLK_PERIOD = 40;

    logic                  clk;
    logic                  rst_i;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       inst_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       debug_wb_pc_o;
    logic [XLEN-1:0]       debug_wb_inst_o;
    logic [3:0]            debug_wb_rf_wen_o;
    logic [REG_ADDR_W-1:0] debug_wb_rf_wnum_o;
    logic [XLEN-1:0]       debug_wb_rf_wdata_o;
    logic                  debug_wb_ine_o;

    // golden columns, one entry per line
    logic                  g_valid [$];
    logic [XLEN-1:0]       g_pc [$];
    logic [XLEN-1:0]       g_inst [$];
    logic [3:0]            g_wen [$];
    logic [REG_ADDR_W-1:0] g_wnum [$];
    logic [XLEN-1:0]       g_wdata [$];
    logic                  g_ine [$];

    int num_lines = 0;
    int pass_count = 0;
    int fail_count = 0;
    int test_errs = 0;
    int in_flight [$];
    bit load_ok;

    backend i_backend (
        .clk                (clk),
        .rst_i              (rst_i),
        .inst_valid_i       (inst_valid_i),
        .inst_i             (inst_i),
        .pc_i               (pc_i),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_inst_o    (debug_wb_inst_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o),
        .debug_wb_ine_o     (debug_wb_ine_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_golden();
        int fd;
        int r;
        int n;
        string line;
        logic [31:0] v;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] wen;
        logic [31:0] wnum;
        logic [31:0] wdata;
        logic [31:0] ine;
        fd = $fopen("backend_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", v, pc, inst, wen, wnum, wdata, ine);
                    // comment and blank lines give fewer fields
                    if (n == 7) begin
                        g_valid.push_back(v[0]);
                        g_pc.push_back(pc);
                        g_inst.push_back(inst);
                        g_wen.push_back(wen[3:0]);
                        g_wnum.push_back(wnum[REG_ADDR_W-1:0]);
                        g_wdata.push_back(wdata);
                        g_ine.push_back(ine[0]);
                    end
                end
            end
            $fclose(fd);
        end
        num_lines = g_valid.size();
        load_ok = (fd != 0) && (num_lines > 0);
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s pc: expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_inst(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s inst: expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_wen(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("ERROR %s wen: expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] exp,
                             input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s wnum: expected %0d actual %0d", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s wdata: expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ine(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s ine: expected %b actual %b", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("ok        %s", name);
        end else begin
            fail_count++;
            $display("mismatch  %s (%0d wrong fields)", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic check_line(input int idx);
        string name;
        name = $sformatf("line %0d pc %h", idx + 1, g_pc[idx]);
        check_pc(name, g_pc[idx], debug_wb_pc_o);
        check_inst(name, g_inst[idx], debug_wb_inst_o);
        check_wen(name, g_wen[idx], debug_wb_rf_wen_o);
        // number and data only mean something with a write
        if (g_wen[idx] != 4'h0) begin
            check_reg(name, g_wnum[idx], debug_wb_rf_wnum_o);
            check_data(name, g_wdata[idx], debug_wb_rf_wdata_o);
        end
        check_ine(name, g_ine[idx], debug_wb_ine_o);
        close_test(name);
    endtask

    // watchdog
    initial begin
        wait (num_lines > 0);
        #((num_lines + 10) * CLK_PERIOD);
        $display("watchdog: run timed out after %0d cycles", num_lines + 10);
        $display("test failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        load_golden();
        if (!load_ok) begin
            $display("golden file could not be opened or held no lines");
            $display("test failed");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_i = 1'b0;
            check_wen("reset", 4'h0, debug_wb_rf_wen_o);
            check_ine("reset", 1'b0, debug_wb_ine_o);
            close_test("reset");
            for (int cyc = 0; cyc < num_lines + 2; cyc++) begin
                @(negedge clk);
                // line driven two falling edges ago is now in writeback
                if (cyc >= 2) begin
                    check_line(in_flight.pop_front());
                end
                if (cyc < num_lines) begin
                    inst_valid_i = g_valid[cyc];
                    inst_i       = g_inst[cyc];
                    pc_i         = g_pc[cyc];
                    in_flight.push_back(cyc);
                end else begin
                    inst_valid_i = 1'b0;
                end
            end
            $display("tests: %0d ok, %0d failing", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
backend_pkg.sv
id.sv
regfile.sv
dispatch.sv
ex.sv
backend.sv
tb_backend.sv
